// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int XLEN    = 32;
    localparam int REG_W   = 5;
    localparam int SHAMT_W = $clog2(XLEN);
    localparam int IMM_W   = 16;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f
    } opcode_e;

    // r-type function code, instr[5:0]
    typedef enum logic [5:0] {
        F_SLL = 6'h00,
        F_SRL = 6'h02,
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_XOR = 6'h26,
        F_SLT = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

endpackage

`default_nettype wire

// ==== src/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    // queue entries, also the credits the instruction source starts with
    localparam int unsigned QUEUE_DEPTH    = 4;
    localparam int unsigned QUEUE_PTR_W    = $clog2(QUEUE_DEPTH);

    // credits granted by the result consumer out of reset
    localparam int unsigned RESULT_CREDITS = 2;

    // wide enough for 0..QUEUE_DEPTH and 0..RESULT_CREDITS
    localparam int unsigned CREDIT_W       = 3;

endpackage

`default_nettype wire

// ==== src/stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface stage_if
    import isa_pkg::*;
();

    logic               valid;
    alu_op_e            alu_op;
    logic [XLEN-1:0]    operand_a;
    logic [XLEN-1:0]    operand_b;  // rt value or extended immediate
    logic [SHAMT_W-1:0] shamt;
    logic [REG_W-1:0]   rd;
    logic               reg_write;

    modport producer (
        output valid, alu_op, operand_a, operand_b, shamt, rd, reg_write
    );

    modport consumer (
        input valid, alu_op, operand_a, operand_b, shamt, rd, reg_write
    );

endinterface

`default_nettype wire

// ==== src/instr_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_queue
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic            i_clock,
    input  logic            i_reset,
    input  logic            i_instr_valid,
    input  logic [XLEN-1:0] i_instr,
    input  logic            advance,
    output logic            head_valid,
    output logic [XLEN-1:0] head_instr,
    output logic            o_instr_credit
);

    logic [XLEN-1:0]        mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [CREDIT_W-1:0]    count;
    logic                   pop;

    assign head_valid = (count != '0);
    assign head_instr = mem[rd_ptr];
    assign pop        = advance && head_valid;

    // source only pushes while holding a credit, so no full check
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            o_instr_credit <= 1'b0;
        end else begin
            if (i_instr_valid)
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count          <= count + CREDIT_W'(i_instr_valid) - CREDIT_W'(pop);
            o_instr_credit <= pop;  // one credit back per pop
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_instr_valid)
            mem[wr_ptr] <= i_instr;
    end

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import isa_pkg::*;
(
    input  logic             i_clock,
    input  logic             i_reset,
    input  logic             head_valid,
    input  logic [XLEN-1:0]  head_instr,
    input  logic             wb_en,
    input  logic [REG_W-1:0] wb_rd,
    input  logic [XLEN-1:0]  wb_data,
    stage_if.consumer        fwd,
    input  logic [XLEN-1:0]  fwd_result,
    stage_if.producer        dec
);

    logic [XLEN-1:0]  regs [2**REG_W];
    opcode_e          opcode;
    funct_e           funct;
    logic [REG_W-1:0] rs;
    logic [REG_W-1:0] rt;
    logic [REG_W-1:0] rd;
    logic [IMM_W-1:0] imm16;
    logic [XLEN-1:0]  rs_val;
    logic [XLEN-1:0]  rt_val;
    logic [XLEN-1:0]  imm_ext;
    logic             fwd_ok;
    logic             known;
    logic             use_imm;
    alu_op_e          op;

    assign opcode = opcode_e'(head_instr[31:26]);
    assign funct  = funct_e'(head_instr[5:0]);
    assign rs     = head_instr[25:21];
    assign rt     = head_instr[20:16];
    assign rd     = head_instr[15:11];
    assign imm16  = head_instr[IMM_W-1:0];

    // write-back lands on the same edge this stage is captured
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < 2**REG_W; i++)
                regs[i] <= '0;
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;  // sender never enables rd 0
        end
    end

    // execute result overrides the register file
    assign fwd_ok = fwd.valid && fwd.reg_write && (fwd.rd != '0);
    assign rs_val = (rs == '0) ? '0 : (fwd_ok && fwd.rd == rs) ? fwd_result : regs[rs];
    assign rt_val = (rt == '0) ? '0 : (fwd_ok && fwd.rd == rt) ? fwd_result : regs[rt];

    always_comb begin
        known   = 1'b1;
        use_imm = 1'b1;
        op      = ALU_ADD;
        imm_ext = {{(XLEN-IMM_W){imm16[IMM_W-1]}}, imm16};  // addi
        case (opcode)
            OP_RTYPE: begin
                use_imm = 1'b0;
                case (funct)
                    F_ADD:   op = ALU_ADD;
                    F_SUB:   op = ALU_SUB;
                    F_AND:   op = ALU_AND;
                    F_OR:    op = ALU_OR;
                    F_XOR:   op = ALU_XOR;
                    F_SLT:   op = ALU_SLT;
                    F_SLL:   op = ALU_SLL;
                    F_SRL:   op = ALU_SRL;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDI: op = ALU_ADD;
            OP_ANDI: begin
                op      = ALU_AND;
                imm_ext = {{(XLEN-IMM_W){1'b0}}, imm16};
            end
            OP_ORI: begin
                op      = ALU_OR;
                imm_ext = {{(XLEN-IMM_W){1'b0}}, imm16};
            end
            OP_LUI: begin
                op      = ALU_LUI;
                imm_ext = {{(XLEN-IMM_W){1'b0}}, imm16};
            end
            default: known = 1'b0;
        endcase
    end

    assign dec.valid     = head_valid && known;  // unknown encodings become bubbles
    assign dec.alu_op    = op;
    assign dec.operand_a = rs_val;
    assign dec.operand_b = use_imm ? imm_ext : rt_val;
    assign dec.shamt     = head_instr[10:6];
    assign dec.rd        = use_imm ? rt : rd;
    assign dec.reg_write = known;

endmodule

`default_nettype wire

// ==== src/id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
    input  logic      i_clock,
    input  logic      i_reset,
    input  logic      advance,
    stage_if.consumer dec,
    stage_if.producer ex
);

    // control bits
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            ex.valid     <= 1'b0;
            ex.reg_write <= 1'b0;
        end else if (advance) begin
            ex.valid     <= dec.valid;
            ex.reg_write <= dec.reg_write && dec.valid;  // bubbles never write
        end
    end

    // payload, held while the pipe is stalled
    always_ff @(posedge i_clock) begin
        if (advance) begin
            ex.alu_op    <= dec.alu_op;
            ex.operand_a <= dec.operand_a;
            ex.operand_b <= dec.operand_b;
            ex.shamt     <= dec.shamt;
            ex.rd        <= dec.rd;
        end
    end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import isa_pkg::*;
(
    stage_if.consumer       ex,
    output logic [XLEN-1:0] result
);

    logic signed [XLEN-1:0] a_s;
    logic signed [XLEN-1:0] b_s;

    assign a_s = ex.operand_a;
    assign b_s = ex.operand_b;

    always_comb begin
        case (ex.alu_op)
            ALU_ADD: result = ex.operand_a + ex.operand_b;  // wraps
            ALU_SUB: result = ex.operand_a - ex.operand_b;
            ALU_AND: result = ex.operand_a & ex.operand_b;
            ALU_OR:  result = ex.operand_a | ex.operand_b;
            ALU_XOR: result = ex.operand_a ^ ex.operand_b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, (a_s < b_s)};
            // shifts act on rt, which decode puts in operand_b
            ALU_SLL: result = ex.operand_b << ex.shamt;
            ALU_SRL: result = ex.operand_b >> ex.shamt;
            ALU_LUI: result = {ex.operand_b[IMM_W-1:0], {(XLEN-IMM_W){1'b0}}};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/result_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_sender
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic             i_clock,
    input  logic             i_reset,
    stage_if.consumer        ex,
    input  logic [XLEN-1:0]  result,
    input  logic             i_result_credit,
    output logic             advance,
    output logic             wb_en,
    output logic [REG_W-1:0] wb_rd,
    output logic [XLEN-1:0]  wb_data,
    output logic             o_result_valid,
    output logic [REG_W-1:0] o_result_rd,
    output logic [XLEN-1:0]  o_result_data
);

    logic [CREDIT_W-1:0] credits;
    logic                send;

    // stall only when a result is waiting and no credit is left
    assign advance = !(ex.valid && credits == '0);
    assign send    = advance && ex.valid;

    assign wb_en   = send && ex.reg_write && (ex.rd != '0);
    assign wb_rd   = ex.rd;
    assign wb_data = result;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            credits        <= CREDIT_W'(RESULT_CREDITS);
            o_result_valid <= 1'b0;
        end else begin
            credits        <= credits - CREDIT_W'(send) + CREDIT_W'(i_result_credit);
            o_result_valid <= send;
        end
    end

    always_ff @(posedge i_clock) begin
        if (send) begin
            o_result_rd   <= ex.rd;
            o_result_data <= result;
        end
    end

endmodule

`default_nettype wire

// ==== src/alu_slice_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_slice_top
    import isa_pkg::*;
(
    input  logic             i_clock,
    input  logic             i_reset,
    input  logic             i_instr_valid,
    input  logic [XLEN-1:0]  i_instr,
    output logic             o_instr_credit,
    output logic             o_result_valid,
    output logic [REG_W-1:0] o_result_rd,
    output logic [XLEN-1:0]  o_result_data,
    input  logic             i_result_credit
);

    logic             advance;
    logic             head_valid;
    logic [XLEN-1:0]  head_instr;
    logic             wb_en;
    logic [REG_W-1:0] wb_rd;
    logic [XLEN-1:0]  wb_data;
    logic [XLEN-1:0]  ex_result;

    stage_if dec_bus ();  // decode -> id_ex_reg
    stage_if ex_bus ();   // id_ex_reg -> execute, sender, forwarding

    instr_queue u_queue (
        .i_clock, .i_reset, .i_instr_valid, .i_instr, .advance,
        .head_valid, .head_instr, .o_instr_credit
    );

    decode_stage u_decode (
        .i_clock, .i_reset, .head_valid, .head_instr,
        .wb_en, .wb_rd, .wb_data,
        .fwd(ex_bus), .fwd_result(ex_result), .dec(dec_bus)
    );

    id_ex_reg u_id_ex (.i_clock, .i_reset, .advance, .dec(dec_bus), .ex(ex_bus));

    execute_stage u_execute (.ex(ex_bus), .result(ex_result));

    result_sender u_sender (
        .i_clock, .i_reset, .ex(ex_bus), .result(ex_result), .i_result_credit,
        .advance, .wb_en, .wb_rd, .wb_data,
        .o_result_valid, .o_result_rd, .o_result_data
    );

endmodule

`default_nettype wire

// ==== dv/alu_slice_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_slice_checker
    import pipe_pkg::*;
(
    input logic i_clock,
    input logic i_reset,
    input logic i_instr_valid,
    input logic o_instr_credit,
    input logic o_result_valid,
    input logic i_result_credit
);

    int outstanding;   // results sent, credit not yet back
    int pushes;
    int credits_back;
    int fail_count = 0;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            outstanding  <= 0;
            pushes       <= 0;
            credits_back <= 0;
        end else begin
            outstanding  <= outstanding + int'(o_result_valid) - int'(i_result_credit);
            pushes       <= pushes + int'(i_instr_valid);
            credits_back <= credits_back + int'(o_instr_credit);
        end
    end

    result_within_credits: assert property (@(posedge i_clock) disable iff (i_reset)
        o_result_valid |-> outstanding < int'(RESULT_CREDITS))
        else begin
            $error("result sent with no result credit left");
            fail_count++;
        end

    credit_after_push: assert property (@(posedge i_clock) disable iff (i_reset)
        o_instr_credit |-> credits_back < pushes)
        else begin
            $error("instruction credit returned without a matching push");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge i_clock)
        $past(i_reset) |-> !o_result_valid && !o_instr_credit)
        else begin
            $error("output pulse during or right after reset");
            fail_count++;
        end

endmodule

bind alu_slice_top alu_slice_checker u_checker (
    .i_clock(i_clock),
    .i_reset(i_reset),
    .i_instr_valid(i_instr_valid),
    .o_instr_credit(o_instr_credit),
    .o_result_valid(o_result_valid),
    .i_result_credit(i_result_credit)
);

`default_nettype wire

// ==== dv/alu_slice_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_slice_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int RESET_CYCLES   = 8;
    localparam int LOAD_ROUNDS    = 3;
    localparam int N_RTYPE        = LOAD_ROUNDS * 16;
    localparam int N_ITYPE        = 16;
    localparam int N_FWD          = 9;
    localparam int N_STALL        = 24;
    localparam int N_BURST        = 32;
    localparam int TOTAL_INSTR    = 1 + N_RTYPE + N_ITYPE + N_FWD + N_STALL + N_BURST;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_INSTR + RESET_CYCLES;
    localparam logic [5:0] R_FUNCTS [8] = '{F_ADD, F_SUB, F_AND, F_OR,
                                            F_XOR, F_SLT, F_SLL, F_SRL};
    localparam logic [5:0] I_OPS [4] = '{OP_ADDI, OP_ANDI, OP_ORI, OP_LUI};

    logic             i_clock = 1'b0;
    logic             i_reset = 1'b1;
    logic             i_instr_valid = 1'b0;
    logic [XLEN-1:0]  i_instr = '0;
    logic             i_result_credit = 1'b0;
    logic             o_instr_credit;
    logic             o_result_valid;
    logic [REG_W-1:0] o_result_rd;
    logic [XLEN-1:0]  o_result_data;

    logic [XLEN-1:0]  stim_mem [TOTAL_INSTR];
    logic [REG_W-1:0] exp_rd_mem [TOTAL_INSTR];
    logic [XLEN-1:0]  exp_data_mem [TOTAL_INSTR];
    logic [XLEN-1:0]  model_regs [32];
    int stim_wr = 0;
    int stim_rd = 0;
    int exp_wr = 0;
    int exp_rd = 0;
    int avail = QUEUE_DEPTH;  // instruction credits held by the source
    int credit_due[$];
    int cycle = 0;
    int checked = 0;
    int err_main = 0;
    int err_source = 0;
    int err_result = 0;
    int test_num = 0;
    int test_err_base = 0;
    string test_name;
    logic hold_credits = 1'b0;

    alu_slice_top uut (
        .i_clock, .i_reset, .i_instr_valid, .i_instr, .o_instr_credit,
        .o_result_valid, .o_result_rd, .o_result_data, .i_result_credit
    );

    always #20 i_clock = ~i_clock;

    // bound assertion failures count too
    function automatic int total_errors();
        return err_main + err_source + err_result + uut.u_checker.fail_count;
    endfunction

    function automatic logic [31:0] r_op(input logic [5:0] fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_op(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] random_instr();
        int sel;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        sel = int'($urandom_range(11));
        rs  = 5'($urandom_range(15));
        rt  = 5'($urandom_range(15));
        rd  = 5'($urandom_range(15));  // rd 0 shows up now and then
        if (sel < 8)
            return r_op(R_FUNCTS[sel], rs, rt, rd, 5'($urandom));
        return i_op(I_OPS[sel - 8], rs, rt, 16'($urandom));
    endfunction

    // golden model runs in issue order on its own register file
    task automatic issue(input logic [31:0] instr);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        ok;
        a   = model_regs[instr[25:21]];
        b   = model_regs[instr[20:16]];
        dst = instr[20:16];
        res = '0;
        ok  = 1'b1;
        if (instr[31:26] == OP_RTYPE) begin
            dst = instr[15:11];
            case (instr[5:0])
                F_ADD:   res = a + b;
                F_SUB:   res = a - b;
                F_AND:   res = a & b;
                F_OR:    res = a | b;
                F_XOR:   res = a ^ b;
                F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                F_SLL:   res = b << instr[10:6];
                F_SRL:   res = b >> instr[10:6];
                default: ok = 1'b0;
            endcase
        end else begin
            case (instr[31:26])
                OP_ADDI: res = a + {{16{instr[15]}}, instr[15:0]};
                OP_ANDI: res = a & {16'h0000, instr[15:0]};
                OP_ORI:  res = a | {16'h0000, instr[15:0]};
                OP_LUI:  res = {instr[15:0], 16'h0000};
                default: ok = 1'b0;
            endcase
        end
        stim_mem[stim_wr] = instr;
        stim_wr = stim_wr + 1;
        if (ok) begin
            exp_rd_mem[exp_wr]   = dst;
            exp_data_mem[exp_wr] = res;
            exp_wr = exp_wr + 1;
            if (dst != 5'd0)
                model_regs[dst] = res;
        end
    endtask

    // returns once every result is seen and every instruction credit is back
    task automatic drain();
        while (stim_rd != stim_wr || avail != QUEUE_DEPTH || exp_rd != exp_wr)
            @(negedge i_clock);
        repeat (3) @(negedge i_clock);  // idle so a stray pulse shows up
    endtask

    task automatic begin_test(input string name);
        test_num      = test_num + 1;
        test_name     = name;
        test_err_base = total_errors();
    endtask

    task automatic end_test();
        int errs;
        errs = total_errors() - test_err_base;
        $display("test %0d %s: %s (%0d errors)", test_num, test_name,
                 (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    // instruction source pushes only while holding a credit
    always @(posedge i_clock) begin
        if (i_reset) begin
            i_instr_valid <= 1'b0;
            avail = QUEUE_DEPTH;
        end else begin
            if (o_instr_credit)
                avail = avail + 1;
            assert (avail <= int'(QUEUE_DEPTH)) else begin
                $display("more instruction credits returned than sent at %0t", $time);
                err_source++;
            end
            if (stim_rd < stim_wr && avail > 0) begin
                i_instr_valid <= 1'b1;
                i_instr       <= stim_mem[stim_rd];
                stim_rd = stim_rd + 1;
                avail   = avail - 1;
            end else begin
                i_instr_valid <= 1'b0;
            end
        end
    end

    // consumer returns each credit 0 to 5 cycles late unless held
    always @(posedge i_clock) begin
        if (i_reset) begin
            i_result_credit <= 1'b0;
            credit_due.delete();
        end else begin
            if (o_result_valid)
                credit_due.push_back(cycle + int'($urandom_range(5)));
            if (!hold_credits && credit_due.size() != 0 && credit_due[0] <= cycle) begin
                void'(credit_due.pop_front());
                i_result_credit <= 1'b1;
            end else begin
                i_result_credit <= 1'b0;
            end
        end
    end

    always @(posedge i_clock) begin
        if (!i_reset && o_result_valid) begin
            assert (exp_rd < exp_wr) else begin
                $display("result sent at %0t with none expected", $time);
                err_result++;
            end
            if (exp_rd < exp_wr) begin
                assert (o_result_rd == exp_rd_mem[exp_rd]) else begin
                    $display("ERR %0t o_result_rd expected %0d got %0d",
                             $time, exp_rd_mem[exp_rd], o_result_rd);
                    err_result++;
                end
                assert (o_result_data == exp_data_mem[exp_rd]) else begin
                    $display("ERR %0t o_result_data expected %h got %h",
                             $time, exp_data_mem[exp_rd], o_result_data);
                    err_result++;
                end
                exp_rd  = exp_rd + 1;
                checked = checked + 1;
            end
        end
    end

    always @(posedge i_clock) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, pipeline did not drain", cycle);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        void'($urandom(32'h1865_5f8d));
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        repeat (RESET_CYCLES) @(posedge i_clock);
        i_reset <= 1'b0;

        begin_test("reset and first add");
        repeat (2) begin
            @(negedge i_clock);
            assert (!o_result_valid && !o_instr_credit) else begin
                $display("output pulse right after reset at %0t", $time);
                err_main++;
            end
        end
        issue(r_op(F_ADD, 5'd1, 5'd2, 5'd3, 5'd0));
        drain();
        end_test();

        begin_test("r-type on random operands");
        for (int r = 0; r < LOAD_ROUNDS; r++) begin
            for (int k = 1; k <= 4; k++) begin
                issue(i_op(OP_ADDI, 5'd0, 5'(k), 16'($urandom)));
                issue(i_op(OP_ORI, 5'(k), 5'(k), 16'($urandom)));
            end
            for (int f = 0; f < 8; f++)
                issue(r_op(R_FUNCTS[f], 5'($urandom_range(4, 1)), 5'($urandom_range(4, 1)),
                           5'($urandom_range(8, 1)), 5'($urandom)));
        end
        drain();
        end_test();

        begin_test("i-type extension");
        for (int n = 0; n < N_ITYPE; n++) begin
            rs  = 5'($urandom_range(15));
            rt  = 5'($urandom_range(15, 1));
            imm = 16'($urandom);
            case (n % 4)
                0:       issue(i_op(OP_ADDI, rs, rt, imm | 16'h8000));  // negative imm
                1:       issue(i_op(OP_ANDI, rs, rt, imm));
                2:       issue(i_op(OP_ORI, rs, rt, imm));
                default: issue(i_op(OP_LUI, 5'd0, rt, imm));
            endcase
        end
        drain();
        end_test();

        begin_test("forwarding, r0 and unsupported");
        issue(i_op(OP_ADDI, 5'd0, 5'd5, 16'd7));
        issue(r_op(F_ADD, 5'd5, 5'd5, 5'd6, 5'd0));
        issue(r_op(F_SUB, 5'd6, 5'd5, 5'd7, 5'd0));
        issue(r_op(F_SLL, 5'd0, 5'd7, 5'd8, 5'd3));
        issue(i_op(OP_ADDI, 5'd0, 5'd0, 16'd123));  // sent with rd 0 but never written
        issue(r_op(F_ADD, 5'd0, 5'd0, 5'd9, 5'd0));
        issue(i_op(6'h23, 5'd5, 5'd10, 16'h0004));  // load is dropped
        issue(r_op(6'h08, 5'd5, 5'd0, 5'd10, 5'd0));  // jr is dropped
        issue(r_op(F_ADD, 5'd10, 5'd5, 5'd11, 5'd0));
        drain();
        end_test();

        begin_test("result credits withheld");
        for (int s = 0; s < 2; s++) begin
            hold_credits = 1'b1;
            for (int n = 0; n < N_STALL / 2; n++)
                issue(random_instr());
            repeat (40) @(negedge i_clock);
            hold_credits = 1'b0;
            repeat (4) @(negedge i_clock);
        end
        drain();
        end_test();

        begin_test("full credit burst");
        for (int n = 0; n < N_BURST; n++)
            issue(random_instr());
        drain();
        end_test();

        $display("%0d tests, %0d results checked, %0d errors, %0d of them assertion failures",
                 test_num, checked, total_errors(), uut.u_checker.fail_count);
        if (total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== alu_slice.f ====
src/isa_pkg.sv
src/pipe_pkg.sv
src/stage_if.sv
src/instr_queue.sv
src/decode_stage.sv
src/id_ex_reg.sv
src/execute_stage.sv
src/result_sender.sv
src/alu_slice_top.sv
dv/alu_slice_checker.sv
dv/alu_slice_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module alu_slice_tb \
		-f alu_slice.f -o alu_slice_sim
	-./obj_dir/alu_slice_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG) || ! grep -q "All checks passed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
